// File: axi_mux_stim.txt
// Columns in hex: port id addr beats first_data, one write per line
// B resp is expected to equal the low two bits of addr
0 3 00001000 1 a0000000
1 5 00002005 2 b1000010
2 a 0000300a 4 c2000020
3 f 0000400f 3 d3000030
0 1 00001101 3 a0000100
1 5 00002106 1 b1000110
2 0 00003103 2 c2000120
3 7 00004100 4 d3000130
0 c 0000120e 2 a0000200
1 2 00002201 4 b1000210
2 a 00003202 1 c2000220
3 4 00004203 2 d3000230
0 3 00001303 4 a0000300
1 e 00002300 3 b1000310
2 6 00003301 3 c2000320
3 9 00004302 1 d3000330
0 0 00001402 1 a0000400
1 8 00002403 2 b1000410
2 b 00003400 4 c2000420
3 d 00004401 3 d3000430
0 6 00001501 2 a0000500
1 1 00002502 1 b1000510
2 f 00003503 2 c2000520
3 2 00004500 4 d3000530

// File: filelist.f
mux_ctrl_pkg.sv
axi_chan_pkg.sv
spill_reg.sv
aw_arbiter.sv
w_route.sv
b_route.sv
axi_mux.sv
tb_axi_mux.sv

// File: Makefile
TOP = tb_axi_mux

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f filelist.f -o $(TOP) --Mdir obj_dir
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_axi_mux.sv
`timescale 1ns/1ps

module tb_axi_mux
  import axi_chan_pkg::*;
  import mux_ctrl_pkg::*;
();

  localparam int STIM_MAX    = 64;   // Table room in lines
  localparam int COLS        = 5;    // port, id, addr, beats, data
  localparam int LIMIT       = 2000; // Cycles allowed per wait loop
  localparam int STALL_WIN   = 60;   // Cycles with master W ready low
  localparam int MAX_W_TRANS = 4;

  logic                    clk_i, rst_i;
  slv_aw_t [NUM_PORTS-1:0] slv_aw_i;
  port_mask_t              slv_aw_valid_i, slv_aw_ready_o;
  w_t [NUM_PORTS-1:0]      slv_w_i;
  port_mask_t              slv_w_valid_i, slv_w_ready_o;
  slv_b_t [NUM_PORTS-1:0]  slv_b_o;
  port_mask_t              slv_b_valid_o, slv_b_ready_i;
  mst_aw_t                 mst_aw_o;
  logic                    mst_aw_valid_o, mst_aw_ready_i;
  w_t                      mst_w_o;
  logic                    mst_w_valid_o, mst_w_ready_i;
  mst_b_t                  mst_b_i;
  logic                    mst_b_valid_i, mst_b_ready_o;

  logic [31:0] stim_mem [STIM_MAX*COLS];
  int          n_txn;
  int          aw_done [NUM_PORTS]; // AWs taken at each port
  int          aw_acc_q [$];        // Stim lines in port AW acceptance order
  int          aw_count, b_count, w_beat;
  int          w_order_q [$];       // Stim lines in master AW order
  w_t          w_seen_q [$];        // Master W beats not yet matched
  mst_b_t      b_pend_q [$];        // Responses still to send
  logic        w_stall, stall_run;
  int          fails [1:5];
  int          tests_ok, tests_bad;

  axi_mux #(
    .MaxWTrans ( MAX_W_TRANS )
  ) i_axi_mux (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i; // 100 ns period
  end

  // ----------------------------------------
  // Stim table access and reporting
  // ----------------------------------------
  function automatic logic [31:0] stim_field(input int ln, input int col);
    return stim_mem[ln*COLS + col];
  endfunction

  // Line of the k-th write of port p, -1 past the end
  function automatic int nth_line(input int p, input int k);
    int seen;
    seen = 0;
    for (int i = 0; i < n_txn; i++) begin
      if (stim_field(i, 0) == 32'(p)) begin
        if (seen == k) return i;
        seen++;
      end
    end
    return -1;
  endfunction

  task automatic report_mismatch(input int t, input string name,
                                 input logic [63:0] got, input logic [63:0] exp);
    fails[stall_run ? 5 : t]++; // Stall run owns every check made during it
    $display("ERROR %s: got %0h, expected %0h", name, got, exp);
  endtask

  task automatic report_failure(input int t, input string msg);
    fails[stall_run ? 5 : t]++;
    $display("Failure: %s", msg);
  endtask

  task automatic abort_run(input string why);
    $display("Run stopped: %s", why);
    $display("sim failed");
    $finish;
  endtask

  task automatic finish_test(input int t, input string name);
    if (fails[t] == 0) begin
      tests_ok++;
      $display("test %0d %s: ok", t, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", t, name, fails[t]);
    end
  endtask

  task automatic clear_counts();
    foreach (aw_done[i]) begin
      aw_done[i] = 0;
    end
    aw_count = 0;
    b_count  = 0;
    w_beat   = 0;
  endtask

  // ----------------------------------------
  // Port drivers
  // ----------------------------------------
  task automatic send_aws(input int p);
    int      k, ln, t;
    slv_aw_t aw;
    k  = 0;
    ln = nth_line(p, 0);
    while (ln >= 0) begin
      aw.id   = SLV_ID_W'(stim_field(ln, 1));
      aw.addr = stim_field(ln, 2);
      aw.len  = 8'(stim_field(ln, 3) - 1); // Beats minus one
      slv_aw_i[p]       <= aw;
      slv_aw_valid_i[p] <= 1'b1;
      t = 0;
      do begin
        @(posedge clk_i);
        t++;
        if (t > LIMIT) abort_run($sformatf("port %0d AW not accepted in time", p));
      end while (!slv_aw_ready_o[p]);
      aw_done[p]++;
      aw_acc_q.push_back(ln); // Master side must show AWs in this order
      k++;
      ln = nth_line(p, k); // Next AW goes out back to back
    end
    slv_aw_valid_i[p] <= 1'b0;
  endtask

  task automatic send_ws(input int p);
    int k, ln, t, nbeats;
    w_t w;
    k  = 0;
    ln = nth_line(p, 0);
    while (ln >= 0) begin
      t = 0;
      while (aw_done[p] <= k) begin // Burst waits for its own AW
        @(posedge clk_i);
        t++;
        if (t > LIMIT) abort_run($sformatf("port %0d waited too long for its AW", p));
      end
      nbeats = int'(stim_field(ln, 3));
      for (int beat = 0; beat < nbeats; beat++) begin
        w.data = stim_field(ln, 4) + 32'(beat);
        w.strb = '1;
        w.last = (beat == nbeats - 1);
        slv_w_i[p]       <= w;
        slv_w_valid_i[p] <= 1'b1;
        t = 0;
        do begin
          @(posedge clk_i);
          t++;
          if (t > LIMIT) abort_run($sformatf("port %0d W beat not accepted in time", p));
        end while (!slv_w_ready_o[p]);
      end
      slv_w_valid_i[p] <= 1'b0; // Idle until the next burst starts
      k++;
      ln = nth_line(p, k);
    end
  endtask

  task automatic run_traffic();
    fork
      send_aws(0);
      send_aws(1);
      send_aws(2);
      send_aws(3);
      send_ws(0);
      send_ws(1);
      send_ws(2);
      send_ws(3);
    join
  endtask

  task automatic wait_all_b();
    int t;
    t = 0;
    while (b_count < n_txn) begin
      @(negedge clk_i);
      t++;
      if (t > LIMIT) abort_run("not every write got its B response in time");
    end
    if (w_order_q.size() != 0 || w_seen_q.size() != 0) begin
      report_failure(3, "W beats or bursts left unmatched at the end");
    end
  endtask

  // Master W ready held low, AW acceptance must stop at the FIFO depth
  task automatic watch_stall();
    logic over;
    over = 1'b0;
    for (int c = 0; c < STALL_WIN; c++) begin
      @(negedge clk_i);
      if (aw_count > MAX_W_TRANS && !over) begin
        report_failure(5, $sformatf("%0d AWs passed while W was stalled", aw_count));
        over = 1'b1;
      end
    end
    if (slv_aw_ready_o !== '0) report_mismatch(5, "slv_aw_ready_o", slv_aw_ready_o, 0);
    w_stall = 1'b0; // Let the bursts drain
  endtask

  // ----------------------------------------
  // Master side responder and checks
  // ----------------------------------------
  always @(posedge clk_i) begin : responder
    int     p, ln, nbeats;
    w_t     w;
    mst_b_t eb, nb;
    if (rst_i) begin
      mst_aw_ready_i <= 1'b0;
      mst_w_ready_i  <= 1'b0;
      mst_b_valid_i  <= 1'b0;
      slv_b_ready_i  <= '0;
    end else begin
      // Master B ready follows the addressed port alone
      if (mst_b_valid_i && b_pend_q.size() > 0) begin
        eb = b_pend_q[0];
        p  = int'(eb.id[MST_ID_W-1 -: PORT_IDX_W]);
        if (mst_b_ready_o !== slv_b_ready_i[p]) begin
          report_mismatch(4, "mst_b_ready_o", mst_b_ready_o, slv_b_ready_i[p]);
        end
      end
      // B seen at both ends in the same cycle
      if (mst_b_valid_i && mst_b_ready_o && b_pend_q.size() > 0) begin
        eb = b_pend_q.pop_front();
        p  = int'(eb.id[MST_ID_W-1 -: PORT_IDX_W]);
        if (slv_b_valid_o !== port_mask_t'(1 << p)) begin
          report_mismatch(4, "slv_b_valid_o", slv_b_valid_o, 1 << p);
        end
        if (slv_b_o[p].id !== eb.id[SLV_ID_W-1:0]) begin
          report_mismatch(4, "slv_b_o.id", slv_b_o[p].id, eb.id[SLV_ID_W-1:0]);
        end
        if (slv_b_o[p].resp !== eb.resp) begin
          report_mismatch(4, "slv_b_o.resp", slv_b_o[p].resp, eb.resp);
        end
        b_count++;
      end
      // AW matched to the oldest AW taken at a port
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        if (aw_acc_q.size() == 0) begin
          report_failure(2, "master AW with no AW taken at any port");
        end else begin
          ln    = aw_acc_q.pop_front();
          nb.id = {port_idx_t'(stim_field(ln, 0)), SLV_ID_W'(stim_field(ln, 1))};
          if (mst_aw_o.id !== nb.id) report_mismatch(2, "mst_aw_o.id", mst_aw_o.id, nb.id);
          if (mst_aw_o.addr !== stim_field(ln, 2)) begin
            report_mismatch(2, "mst_aw_o.addr", mst_aw_o.addr, stim_field(ln, 2));
          end
          if (mst_aw_o.len !== 8'(stim_field(ln, 3) - 1)) begin
            report_mismatch(2, "mst_aw_o.len", mst_aw_o.len, stim_field(ln, 3) - 1);
          end
          w_order_q.push_back(ln);
        end
        aw_count++;
      end
      if (mst_w_valid_o && mst_w_ready_i) w_seen_q.push_back(mst_w_o); // W may lead its AW
      // Pair beats with bursts in master AW order
      while (w_order_q.size() > 0 && w_seen_q.size() > 0) begin
        ln     = w_order_q[0];
        w      = w_seen_q.pop_front();
        nbeats = int'(stim_field(ln, 3));
        if (w.data !== stim_field(ln, 4) + 32'(w_beat)) begin
          report_mismatch(3, "mst_w_o.data", w.data, stim_field(ln, 4) + 32'(w_beat));
        end
        if (w.strb !== '1) report_mismatch(3, "mst_w_o.strb", w.strb, 4'hf);
        if (w.last !== (w_beat == nbeats - 1)) begin
          report_mismatch(3, "mst_w_o.last", w.last, (w_beat == nbeats - 1));
        end
        if (w_beat == nbeats - 1) begin
          void'(w_order_q.pop_front());
          w_beat  = 0;
          nb.id   = {port_idx_t'(stim_field(ln, 0)), SLV_ID_W'(stim_field(ln, 1))};
          nb.resp = 2'(stim_field(ln, 2)); // Low address bits pick the resp
          b_pend_q.push_back(nb);
        end else begin
          w_beat++;
        end
      end
      mst_aw_ready_i <= 1'($urandom % 2);
      mst_w_ready_i  <= w_stall ? 1'b0 : 1'($urandom % 2);
      slv_b_ready_i  <= port_mask_t'($urandom);
      mst_b_valid_i  <= (b_pend_q.size() > 0);
      if (b_pend_q.size() > 0) mst_b_i <= b_pend_q[0]; // Head holds until taken
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main
    void'($urandom(91282));
    rst_i          = 1'b1;
    slv_aw_i       = '0;
    slv_aw_valid_i = '0;
    slv_w_i        = '0;
    slv_w_valid_i  = '0;
    slv_b_ready_i  = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_i        = '0;
    mst_b_valid_i  = 1'b0;
    w_stall        = 1'b0;
    stall_run      = 1'b0;
    fails          = '{default: 0};
    tests_ok       = 0;
    tests_bad      = 0;
    clear_counts();
    foreach (stim_mem[i]) stim_mem[i] = 32'hffff_ffff; // End marker
    $readmemh("axi_mux_stim.txt", stim_mem);
    n_txn = 0;
    while (n_txn < STIM_MAX && stim_field(n_txn, 0) != 32'hffff_ffff) n_txn++;
    if (n_txn == 0) abort_run("axi_mux_stim.txt holds no transactions");

    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    if (mst_aw_valid_o !== 1'b0) report_mismatch(1, "mst_aw_valid_o", mst_aw_valid_o, 0);
    if (mst_w_valid_o !== 1'b0) report_mismatch(1, "mst_w_valid_o", mst_w_valid_o, 0);
    if (slv_b_valid_o !== '0) report_mismatch(1, "slv_b_valid_o", slv_b_valid_o, 0);
    if (slv_aw_ready_o !== '0) report_mismatch(1, "slv_aw_ready_o", slv_aw_ready_o, 0);
    if (slv_w_ready_o !== '0) report_mismatch(1, "slv_w_ready_o", slv_w_ready_o, 0);
    finish_test(1, "reset state");

    @(posedge clk_i);
    run_traffic();
    wait_all_b();
    finish_test(2, "AW ID prepend and order");
    finish_test(3, "W bursts in AW order");
    finish_test(4, "B routing and ID strip");

    // Same file again with the W channel stalled at first
    @(negedge clk_i);
    clear_counts();
    stall_run = 1'b1;
    w_stall   = 1'b1;
    @(posedge clk_i);
    fork
      run_traffic();
      watch_stall();
    join
    wait_all_b();
    finish_test(5, "W stall back-pressure");

    $display("tests: %0d ok, %0d failed", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: axi_mux.sv
`timescale 1ns/1ps

module axi_mux
  import axi_chan_pkg::*;
  import mux_ctrl_pkg::*;
#(
  parameter int unsigned MaxWTrans = 8,    // Depth of the W route FIFO
  parameter bit          SpillAw   = 1'b1, // Register on master AW
  parameter bit          SpillB    = 1'b0  // Register on master B
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Manager ports
  input  slv_aw_t [NUM_PORTS-1:0] slv_aw_i,
  input  port_mask_t              slv_aw_valid_i,
  output port_mask_t              slv_aw_ready_o,
  input  w_t [NUM_PORTS-1:0]      slv_w_i,
  input  port_mask_t              slv_w_valid_i,
  output port_mask_t              slv_w_ready_o,
  output slv_b_t [NUM_PORTS-1:0]  slv_b_o,
  output port_mask_t              slv_b_valid_o,
  input  port_mask_t              slv_b_ready_i,
  // Master side
  output mst_aw_t                 mst_aw_o,
  output logic                    mst_aw_valid_o,
  input  logic                    mst_aw_ready_i,
  output w_t                      mst_w_o,
  output logic                    mst_w_valid_o,
  input  logic                    mst_w_ready_i,
  input  mst_b_t                  mst_b_i,
  input  logic                    mst_b_valid_i,
  output logic                    mst_b_ready_o
);

  mst_aw_t   arb_aw; // ID already prepended
  logic      arb_aw_valid, arb_aw_ready;
  logic      w_push, w_full;
  port_idx_t w_push_idx;
  slv_b_t    slv_b;

  // ----------------------------------------
  // AW path
  // ----------------------------------------
  aw_arbiter i_aw_arbiter (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .slv_aw_i       ( slv_aw_i       ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .fifo_full_i    ( w_full         ),
    .push_o         ( w_push         ),
    .push_idx_o     ( w_push_idx     ),
    .aw_o           ( arb_aw         ),
    .aw_valid_o     ( arb_aw_valid   ),
    .aw_ready_i     ( arb_aw_ready   )
  );

  spill_reg #(
    .T      ( mst_aw_t ),
    .Bypass ( !SpillAw )
  ) i_aw_spill_reg (
    .clk_i   ( clk_i          ),
    .rst_i   ( rst_i          ),
    .valid_i ( arb_aw_valid   ),
    .ready_o ( arb_aw_ready   ),
    .data_i  ( arb_aw         ),
    .valid_o ( mst_aw_valid_o ),
    .ready_i ( mst_aw_ready_i ),
    .data_o  ( mst_aw_o       )
  );

  // W path, steered by AW order
  w_route #(
    .MaxWTrans ( MaxWTrans )
  ) i_w_route (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .push_i        ( w_push        ),
    .push_idx_i    ( w_push_idx    ),
    .full_o        ( w_full        ),
    .slv_w_i       ( slv_w_i       ),
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .w_o           ( mst_w_o       ),
    .w_valid_o     ( mst_w_valid_o ),
    .w_ready_i     ( mst_w_ready_i )
  );

  // ----------------------------------------
  // B path
  // ----------------------------------------
  b_route #(
    .SpillB ( SpillB )
  ) i_b_route (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .b_i           ( mst_b_i       ),
    .b_valid_i     ( mst_b_valid_i ),
    .b_ready_o     ( mst_b_ready_o ),
    .slv_b_o       ( slv_b         ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_ready_i ( slv_b_ready_i )
  );

  assign slv_b_o = {NUM_PORTS{slv_b}}; // Valid bits pick the receiver

endmodule

// File: b_route.sv
`timescale 1ns/1ps

module b_route
  import axi_chan_pkg::*;
  import mux_ctrl_pkg::*;
#(
  parameter bit SpillB = 1'b0 // Register the B path when set
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  mst_b_t     b_i,
  input  logic       b_valid_i,
  output logic       b_ready_o,
  output slv_b_t     slv_b_o,       // Same payload for every port
  output port_mask_t slv_b_valid_o,
  input  port_mask_t slv_b_ready_i
);

  mst_b_t    b_q;
  logic      b_valid_q;
  port_idx_t b_sel; // Target port from the upper ID bits

  spill_reg #(
    .T      ( mst_b_t ),
    .Bypass ( !SpillB )
  ) i_b_spill_reg (
    .clk_i   ( clk_i                ),
    .rst_i   ( rst_i                ),
    .valid_i ( b_valid_i            ),
    .ready_o ( b_ready_o            ),
    .data_i  ( b_i                  ),
    .valid_o ( b_valid_q            ),
    .ready_i ( slv_b_ready_i[b_sel] ), // Only the addressed port may stall
    .data_o  ( b_q                  )
  );

  assign b_sel = b_q.id[SLV_ID_W +: PORT_IDX_W];

  // Strip the port index
  assign slv_b_o.id   = b_q.id[SLV_ID_W-1:0];
  assign slv_b_o.resp = b_q.resp;

  assign slv_b_valid_o = b_valid_q ? (port_mask_t'(1) << b_sel) : '0;

endmodule

// File: w_route.sv
`timescale 1ns/1ps

module w_route
  import axi_chan_pkg::*;
  import mux_ctrl_pkg::*;
#(
  parameter int unsigned MaxWTrans = 8 // Writes in flight on W
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 push_i,     // AW decision from the arbiter
  input  port_idx_t            push_idx_i,
  output logic                 full_o,
  input  w_t [NUM_PORTS-1:0]   slv_w_i,
  input  port_mask_t           slv_w_valid_i,
  output port_mask_t           slv_w_ready_o,
  output w_t                   w_o,
  output logic                 w_valid_o,
  input  logic                 w_ready_i
);

  localparam int unsigned PtrW = (MaxWTrans > 1) ? $clog2(MaxWTrans) : 1;
  localparam int unsigned CntW = $clog2(MaxWTrans + 1);

  typedef logic [PtrW-1:0] ptr_t;

  port_idx_t       fifo_q [MaxWTrans]; // Winner order of the AWs
  ptr_t            wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;              // Entries held
  logic            empty, pop;
  port_idx_t       head_idx;

  // ----------------------------------------
  // Decision FIFO
  // ----------------------------------------
  assign full_o   = (cnt_q == CntW'(MaxWTrans));
  assign empty    = (cnt_q == '0);
  assign head_idx = fifo_q[rd_ptr_q]; // Port owning the current burst

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= (wr_ptr_q == ptr_t'(MaxWTrans - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)    rd_ptr_q <= (rd_ptr_q == ptr_t'(MaxWTrans - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push_i, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q; // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) fifo_q[wr_ptr_q] <= push_idx_i;
  end

  // ----------------------------------------
  // W steering
  // ----------------------------------------
  assign w_o = slv_w_i[head_idx];

  always_comb begin
    w_valid_o     = 1'b0;
    slv_w_ready_o = '0;
    if (!empty) begin
      w_valid_o               = slv_w_valid_i[head_idx];
      slv_w_ready_o[head_idx] = w_ready_i; // Other ports wait their turn
    end
  end

  assign pop = w_valid_o && w_ready_i && w_o.last; // Burst done, next head

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop |-> !empty)
    else $error("W route popped while empty");

  // Head stays with one port until its last beat
  a_head_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    w_valid_o && w_ready_i && !w_o.last |=> !empty && $stable(head_idx))
    else $error("W route head moved inside a burst");

endmodule

// File: aw_arbiter.sv
`timescale 1ns/1ps

module aw_arbiter
  import axi_chan_pkg::*;
  import mux_ctrl_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  slv_aw_t [NUM_PORTS-1:0] slv_aw_i,
  input  port_mask_t              slv_aw_valid_i,
  output port_mask_t              slv_aw_ready_o,
  input  logic                    fifo_full_i,    // W route cannot take a decision
  output logic                    push_o,         // Record winner in W route
  output port_idx_t               push_idx_o,
  output mst_aw_t                 aw_o,
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i
);

  port_idx_t rr_q, rr_d;             // Port with top priority
  logic      lock_q, lock_d;         // AW pushed but not yet taken
  port_idx_t lock_idx_q, lock_idx_d; // Port held by the lock
  port_idx_t sel_idx, gnt_idx;
  logic      sel_valid;
  slv_aw_t   gnt_aw;

  // ----------------------------------------
  // Round robin search
  // ----------------------------------------
  // Walk from the far end back to rr_q so the nearest request is kept last
  always_comb begin
    port_idx_t cand;
    sel_idx   = rr_q;
    sel_valid = 1'b0;
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      cand = port_idx_t'((int'(rr_q) + i) % NUM_PORTS);
      if (slv_aw_valid_i[cand]) begin
        sel_idx   = cand;
        sel_valid = 1'b1;
      end
    end
  end

  assign gnt_idx    = lock_q ? lock_idx_q : sel_idx; // Lock pins the grant
  assign gnt_aw     = slv_aw_i[gnt_idx];
  assign push_idx_o = gnt_idx;

  // ID prepend, winner index above the port ID
  assign aw_o.id   = {gnt_idx, gnt_aw.id};
  assign aw_o.addr = gnt_aw.addr;
  assign aw_o.len  = gnt_aw.len;

  // ----------------------------------------
  // Handshake and lock control
  // ----------------------------------------
  always_comb begin
    lock_d         = lock_q;
    lock_idx_d     = lock_idx_q;
    rr_d           = rr_q;
    push_o         = 1'b0;
    aw_valid_o     = 1'b0;
    slv_aw_ready_o = '0;
    if (lock_q) begin
      aw_valid_o = 1'b1; // Already pushed, just wait for the transfer
      if (aw_ready_i) begin
        slv_aw_ready_o[gnt_idx] = 1'b1;
        lock_d                  = 1'b0;
      end
    end else if (sel_valid && !fifo_full_i) begin
      aw_valid_o = 1'b1;
      push_o     = 1'b1; // First cycle presented, one push only
      if (aw_ready_i) begin
        slv_aw_ready_o[gnt_idx] = 1'b1;
      end else begin
        lock_d     = 1'b1; // Stalled downstream
        lock_idx_d = sel_idx;
      end
    end
    // Next port gets priority after a transfer
    if (aw_valid_o && aw_ready_i) begin
      rr_d = (gnt_idx == port_idx_t'(NUM_PORTS - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
    end else begin
      rr_q   <= rr_d;
      lock_q <= lock_d;
    end
  end

  always_ff @(posedge clk_i) begin
    lock_idx_q <= lock_idx_d; // Only read while lock_q is set
  end

  // W route FIFO must never overflow
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    fifo_full_i |-> !push_o)
    else $error("AW pushed while W route FIFO full");

  a_one_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(slv_aw_ready_o))
    else $error("More than one port AW ready");

endmodule

// File: spill_reg.sv
`timescale 1ns/1ps

module spill_reg #(
  parameter type T      = logic, // Payload carried through
  parameter bit  Bypass = 1'b0   // Set for plain wires
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    // Slot A takes input, slot B catches what A cannot hand on
    T     a_data_q, b_data_q;
    logic a_full_q, b_full_q;
    logic a_fill, a_drain, b_fill, b_drain;

    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q; // A empties out or moves into B
    assign b_fill  = a_drain && !ready_i;   // Output stalled, park A in B
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) a_full_q <= a_fill; // Refill wins over drain
        if (b_fill || b_drain) b_full_q <= b_fill;
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) a_data_q <= data_i;
      if (b_fill) b_data_q <= a_data_q;
    end

    assign ready_o = !a_full_q || !b_full_q; // Room in at least one slot
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q; // B is always the older item

    // Output holds while stalled, also across the A to B move
    a_hold_out: assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> valid_o && $stable(data_o))
      else $error("spill_reg output changed while stalled");
  end

endmodule

// File: axi_chan_pkg.sv
package axi_chan_pkg;

  import mux_ctrl_pkg::*; // Port index width widens the master side ID

  // ----------------------------------------
  // Channel widths
  // ----------------------------------------
  localparam int unsigned SLV_ID_W = 4;                     // ID at a manager port
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned STRB_W   = DATA_W / 8;            // One strobe per byte
  localparam int unsigned MST_ID_W = SLV_ID_W + PORT_IDX_W; // Port index sits on top

  // ----------------------------------------
  // AW channel
  // ----------------------------------------
  typedef struct packed {
    logic [SLV_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [7:0]          len;  // Beats minus one
  } slv_aw_t;

  typedef struct packed {
    logic [MST_ID_W-1:0] id;   // {port index, port ID}
    logic [ADDR_W-1:0]   addr;
    logic [7:0]          len;
  } mst_aw_t;

  // W channel, same on both sides
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last; // Final beat of the burst
  } w_t;

  // ----------------------------------------
  // B channel
  // ----------------------------------------
  typedef struct packed {
    logic [SLV_ID_W-1:0] id;
    logic [1:0]          resp;
  } slv_b_t;

  typedef struct packed {
    logic [MST_ID_W-1:0] id;
    logic [1:0]          resp;
  } mst_b_t;

endpackage

// File: mux_ctrl_pkg.sv
package mux_ctrl_pkg;

  // ----------------------------------------
  // Manager port count and steering types
  // ----------------------------------------
  localparam int unsigned NUM_PORTS  = 4; // Manager ports joined by the mux
  // Width of a port index, at least one bit
  localparam int unsigned PORT_IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  typedef logic [PORT_IDX_W-1:0] port_idx_t;  // Selects one port
  typedef logic [NUM_PORTS-1:0]  port_mask_t; // One bit per port

endpackage
